//--- run_sim.sh
#!/bin/sh
# Build the GPIO testbench with Verilator, run it and judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gpio_tb -f vlog.f -o gpio_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/gpio_sim > sim.log 2>&1 || echo "Simulation exited with an error status" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } \
    || { grep -q "Everything OK" sim.log && echo "PASS"; } || { echo "FAIL"; exit 1; }

//--- source/gpio_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_apb_regs
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  data_t pwdata,
    input  strb_t pstrb,
    output logic  pready,
    output data_t prdata,
    output logic  pslverr,

    input  logic  pause_req,  // Synchronized
    output logic  pause_ack,

    input  gpio_t idr,
    output gpio_t odr,
    output gpio_t moder,
    output gpio_t otyper,
    output data_t fsr [FSR_WORDS],
    output gpio_t ier,

    output logic  irq
);

    logic [ADDR_WIDTH-WORD_SHIFT-1:0] index;
    data_t                            lane_mask;
    data_t                            rd_data;
    logic                             idx_hit;
    logic                             access_err;
    logic                             paused;

    function automatic data_t merge_lanes(input data_t old_word, input data_t new_word,
                                          input data_t strobe_mask);
        return (new_word & strobe_mask) | (old_word & ~strobe_mask);
    endfunction

    assign index  = paddr[ADDR_WIDTH-1:WORD_SHIFT];
    assign paused = pause_req && pause_ack;

    // Expand byte strobes to a bit mask
    always_comb begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
            lane_mask[i*8 +: 8] = {8{pstrb[i]}};
        end
    end

    // Read mux and address check
    always_comb begin
        rd_data = '0;
        idx_hit = 1'b1;
        case (index)
            REG_IDR:    rd_data = idr;
            REG_ODR:    rd_data = odr;
            REG_MODER:  rd_data = moder;
            REG_OTYPER: rd_data = otyper;
            REG_FSR0:   rd_data = fsr[0];
            REG_FSR1:   rd_data = fsr[1];
            REG_IER:    rd_data = ier;
            default:    idx_hit = 1'b0;  // Unmapped
        endcase
    end

    // IDR is read only
    assign access_err = !idx_hit || (pwrite && index == REG_IDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            odr       <= '0;
            moder     <= '0;
            otyper    <= '0;
            fsr       <= '{default: '0};
            ier       <= '0;
            pready    <= 1'b0;
            prdata    <= '0;
            pslverr   <= 1'b0;
            pause_ack <= 1'b0;
        end else if (paused) begin
            // Frozen, bus stays tied off with an error
        end else if (psel && !pready && !pause_req) begin
            // Setup cycle seen, respond in the first access cycle
            pready  <= 1'b1;
            pslverr <= access_err;
            prdata  <= (pwrite || access_err) ? '0 : rd_data;
            if (pwrite && !access_err) begin
                case (index)
                    REG_ODR:    odr    <= merge_lanes(odr, pwdata, lane_mask);
                    REG_MODER:  moder  <= merge_lanes(moder, pwdata, lane_mask);
                    REG_OTYPER: otyper <= merge_lanes(otyper, pwdata, lane_mask);
                    REG_FSR0:   fsr[0] <= merge_lanes(fsr[0], pwdata, lane_mask);
                    REG_FSR1:   fsr[1] <= merge_lanes(fsr[1], pwdata, lane_mask);
                    REG_IER:    ier    <= merge_lanes(ier, pwdata, lane_mask);
                    default: ;
                endcase
            end
        end else if (psel && penable && pready && !pause_ack) begin
            // Transfer done
            pready  <= 1'b0;
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (pause_req && !pause_ack && !pready) begin
            // Enter pause once no response is outstanding
            pause_ack <= 1'b1;
            pready    <= 1'b1;
            pslverr   <= 1'b1;
            prdata    <= '0;
        end else if (!pause_req && pause_ack) begin
            // Resume
            pause_ack <= 1'b0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            prdata    <= '0;
        end
    end

    // Level interrupt, held low during pause
    assign irq = (|(ier & idr)) && !paused;

    a_err_needs_ready: assert property (
        @(posedge clk) disable iff (rst) pslverr |-> pready
    );

    // pready only answers a selected transfer, or ties off the bus on pause
    a_ready_after_sel: assert property (
        @(posedge clk) disable iff (rst) $rose(pready) |-> $past(psel) || pause_ack
    );

endmodule

`default_nettype wire

//--- source/gpio_bus_pkg.sv
`default_nettype none

package gpio_bus_pkg;

    localparam int ADDR_WIDTH = 12;             // APB address bits
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8; // One strobe per byte lane
    localparam int WORD_SHIFT = 2;              // Byte offset inside a word

    // Word indexes as decoded from paddr[ADDR_WIDTH-1:WORD_SHIFT]
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_IDR    = 'd0; // Read only
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_ODR    = 'd1;
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_MODER  = 'd2;
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_OTYPER = 'd3;
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_FSR0   = 'd4; // Pins 0 to 15
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_FSR1   = 'd5; // Pins 16 to 31
    localparam logic [ADDR_WIDTH-WORD_SHIFT-1:0] REG_IER    = 'd6;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

endpackage

`default_nettype wire

//--- source/gpio_pad_drive.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_pad_drive
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  gpio_t odr,
    input  gpio_t moder,
    input  gpio_t otyper,
    input  data_t fsr [FSR_WORDS],
    input  gpio_t alt_out_1,
    input  gpio_t alt_out_2,
    input  gpio_t alt_out_3,
    output gpio_t pad_out,
    output gpio_t pad_oe
);

    func_t func_sel [GPIO_WIDTH];
    gpio_t sel_val;
    gpio_t next_out;
    gpio_t next_oe;

    always_comb begin
        for (int i = 0; i < GPIO_WIDTH; i++) begin
            // Two bits per pin, packed low pin first
            func_sel[i] = fsr[(2 * i) / DATA_WIDTH][(2 * i) % DATA_WIDTH +: 2];
            unique case (func_sel[i])
                FUNC_GPIO: sel_val[i] = odr[i];
                FUNC_ALT1: sel_val[i] = alt_out_1[i];
                FUNC_ALT2: sel_val[i] = alt_out_2[i];
                FUNC_ALT3: sel_val[i] = alt_out_3[i];
            endcase
            if (otyper[i] == OTYPE_OPEN_DRAIN) begin
                next_oe[i]  = (moder[i] == MODE_OUTPUT) && !sel_val[i]; // Only pull low
                next_out[i] = 1'b0;
            end else begin
                next_oe[i]  = (moder[i] == MODE_OUTPUT);
                next_out[i] = sel_val[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pad_out <= '0;
            pad_oe  <= '0;
        end else begin
            pad_out <= next_out;
            pad_oe  <= next_oe;
        end
    end

    // Pad register lags OTYPER by one cycle
    a_open_drain_low: assert property (
        @(posedge clk) disable iff (rst) (pad_out & $past(otyper)) == '0
    );

endmodule

`default_nettype wire

//--- source/gpio_pin_pkg.sv
`default_nettype none

package gpio_pin_pkg;

    localparam int GPIO_WIDTH = 32;
    localparam int FSR_WORDS  = (2 * GPIO_WIDTH + 31) / 32; // Two function bits per pin

    typedef logic [GPIO_WIDTH-1:0] gpio_t;
    typedef logic [1:0]            func_t;

    // Function select codes
    localparam func_t FUNC_GPIO = 2'd0;
    localparam func_t FUNC_ALT1 = 2'd1;
    localparam func_t FUNC_ALT2 = 2'd2;
    localparam func_t FUNC_ALT3 = 2'd3;

    // Direction bit in MODER
    localparam logic MODE_INPUT  = 1'b0;
    localparam logic MODE_OUTPUT = 1'b1;

    // Output type bit in OTYPER
    localparam logic OTYPE_PUSH_PULL  = 1'b0;
    localparam logic OTYPE_OPEN_DRAIN = 1'b1;

endpackage

`default_nettype wire

//--- source/gpio_sync_stage.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_sync_stage
    import gpio_pin_pkg::*;
#(
    parameter type payload_t = gpio_t
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t async_in,
    output payload_t sync_out
);

    // First flop may go metastable, second one settles it
    payload_t meta_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_q   <= '0;
            sync_out <= '0;
        end else begin
            meta_q   <= async_in;
            sync_out <= meta_q;  // Two cycles from pin to output
        end
    end

endmodule

`default_nettype wire

//--- source/gpio_top.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_top
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  data_t pwdata,
    input  strb_t pstrb,
    output logic  pready,
    output data_t prdata,
    output logic  pslverr,

    input  logic  pause_req,
    output logic  pause_ack,

    output logic  irq,

    input  gpio_t pad_in,
    output gpio_t pad_out,
    output gpio_t pad_oe,

    input  gpio_t alt_out_1,
    input  gpio_t alt_out_2,
    input  gpio_t alt_out_3
);

    gpio_t idr;         // Synchronized pad inputs
    logic  pause_sync;
    gpio_t odr;
    gpio_t moder;
    gpio_t otyper;
    data_t fsr [FSR_WORDS];
    gpio_t ier;

    gpio_sync_stage #(
        .payload_t(gpio_t)
    ) u_pin_sync (
        .clk      (clk),
        .rst      (rst),
        .async_in (pad_in),
        .sync_out (idr)
    );

    gpio_sync_stage #(
        .payload_t(logic)
    ) u_pause_sync (
        .clk      (clk),
        .rst      (rst),
        .async_in (pause_req),
        .sync_out (pause_sync)
    );

    gpio_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_sync),
        .pause_ack (pause_ack),
        .idr       (idr),
        .odr       (odr),
        .moder     (moder),
        .otyper    (otyper),
        .fsr       (fsr),
        .ier       (ier),
        .irq       (irq)
    );

    gpio_pad_drive u_pad (
        .clk       (clk),
        .rst       (rst),
        .odr       (odr),
        .moder     (moder),
        .otyper    (otyper),
        .fsr       (fsr),
        .alt_out_1 (alt_out_1),
        .alt_out_2 (alt_out_2),
        .alt_out_3 (alt_out_3),
        .pad_out   (pad_out),
        .pad_oe    (pad_oe)
    );

endmodule

`default_nettype wire

//--- testbench/gpio_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_tb
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
();

    // Six test groups, none longer than about 400 cycles, plus margin
    localparam int MAX_CYCLES = 3000;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    addr_t paddr = '0;
    logic  psel = 1'b0;
    logic  penable = 1'b0;
    logic  pwrite = 1'b0;
    data_t pwdata = '0;
    strb_t pstrb = '0;
    logic  pause_req = 1'b0;
    gpio_t pad_in = '0;
    gpio_t alt_out_1 = '0;
    gpio_t alt_out_2 = '0;
    gpio_t alt_out_3 = '0;
    logic  pready;
    data_t prdata;
    logic  pslverr;
    logic  pause_ack;
    logic  irq;
    gpio_t pad_out;
    gpio_t pad_oe;

    // Register model
    data_t m_odr = '0;
    data_t m_moder = '0;
    data_t m_otyper = '0;
    data_t m_fsr0 = '0;
    data_t m_fsr1 = '0;
    data_t m_ier = '0;
    gpio_t idr_s1;
    gpio_t idr_s2;      // Pin value as IDR should show it
    logic  pause_s1;
    logic  pause_s2;
    gpio_t m_out;
    gpio_t m_oe;
    gpio_t exp_out_q;
    gpio_t exp_oe_q;
    gpio_t otyper_q;
    logic  exp_err = 1'b0;
    data_t exp_rdata = '0;
    logic  paused_phase = 1'b0;
    gpio_t pin_pattern = '0;   // Level seen on pins nobody drives
    logic [15:0] lfsr_state = 16'd41;
    int    cycle_count = 0;

    always #4 clk = ~clk;

    gpio_top u_gpio_top (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .pad_in    (pad_in),
        .pad_out   (pad_out),
        .pad_oe    (pad_oe),
        .alt_out_1 (alt_out_1),
        .alt_out_2 (alt_out_2),
        .alt_out_3 (alt_out_3)
    );

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic data_t lane_merge(input data_t old_w, input data_t new_w,
                                         input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic data_t model_word(input int idx);
        case (idx)
            REG_IDR:    return idr_s2;
            REG_ODR:    return m_odr;
            REG_MODER:  return m_moder;
            REG_OTYPER: return m_otyper;
            REG_FSR0:   return m_fsr0;
            REG_FSR1:   return m_fsr1;
            REG_IER:    return m_ier;
            default:    return '0;
        endcase
    endfunction

    // One APB transfer, model updated when the DUT takes the write
    task automatic apb_access(input logic wr, input int idx, input data_t wdata,
                              input strb_t strb);
        logic err;
        err = paused_phase || idx > 6 || (wr && idx == 0);
        @(posedge clk);
        paddr   <= addr_t'(idx << WORD_SHIFT);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable   <= 1'b1;
        exp_err   <= err;
        exp_rdata <= (wr || err) ? '0 : model_word(idx);
        if (wr && !err) begin
            case (idx)
                REG_ODR:    m_odr    <= lane_merge(m_odr, wdata, strb);
                REG_MODER:  m_moder  <= lane_merge(m_moder, wdata, strb);
                REG_OTYPER: m_otyper <= lane_merge(m_otyper, wdata, strb);
                REG_FSR0:   m_fsr0   <= lane_merge(m_fsr0, wdata, strb);
                REG_FSR1:   m_fsr1   <= lane_merge(m_fsr1, wdata, strb);
                REG_IER:    m_ier    <= lane_merge(m_ier, wdata, strb);
                default: ;
            endcase
        end
        do @(posedge clk); while (!pready);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input int idx, input data_t wdata, input strb_t strb);
        apb_access(1'b1, idx, wdata, strb);
    endtask

    task automatic read_reg(input int idx);
        apb_access(1'b0, idx, '0, '0);
    endtask

    // Expected pad levels from the pad rule
    always_comb begin : pad_model
        func_t code;
        logic  val;
        for (int p = 0; p < GPIO_WIDTH; p++) begin
            code = (p < 16) ? m_fsr0[2*p +: 2] : m_fsr1[2*(p-16) +: 2];
            case (code)
                FUNC_ALT1: val = alt_out_1[p];
                FUNC_ALT2: val = alt_out_2[p];
                FUNC_ALT3: val = alt_out_3[p];
                default:   val = m_odr[p];
            endcase
            m_oe[p]  = m_moder[p] && !(m_otyper[p] && val);
            m_out[p] = !m_otyper[p] && val;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            idr_s1    <= '0;
            idr_s2    <= '0;
            pause_s1  <= 1'b0;
            pause_s2  <= 1'b0;
            exp_out_q <= '0;
            exp_oe_q  <= '0;
            otyper_q  <= '0;
        end else begin
            idr_s1    <= pad_in;
            idr_s2    <= idr_s1;
            pause_s1  <= pause_req;
            pause_s2  <= pause_s1;
            exp_out_q <= m_out;  // Pad stage register
            exp_oe_q  <= m_oe;
            otyper_q  <= m_otyper;
        end
    end

    // Pad loopback, driven pins read back their own level
    always @(posedge clk) begin
        if (rst) begin
            pad_in <= '0;
        end else begin
            pad_in <= (pad_out & pad_oe) | (pin_pattern & ~pad_oe);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    a_response: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready) |-> (pslverr == exp_err && prdata == exp_rdata))
        else report_error("APB response does not match the register model");

    a_zero_wait: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> pready)
        else report_error("pready low in the first access cycle");

    a_ready_drop: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready && !pause_ack) |=> !pready)
        else report_error("pready still high after the transfer completed");

    a_irq: assert property (@(posedge clk) disable iff (rst)
        irq == ((|(m_ier & idr_s2)) && !(pause_ack && pause_s2)))
        else report_error("irq differs from IER and IDR");

    a_paused_irq: assert property (@(posedge clk) disable iff (rst)
        paused_phase |-> !irq)
        else report_error("irq high while paused");

    a_pad: assert property (@(posedge clk) disable iff (rst)
        pad_out == exp_out_q && pad_oe == exp_oe_q)
        else report_error("pad_out or pad_oe differs from the pad rule");

    a_open_drain: assert property (@(posedge clk) disable iff (rst)
        (pad_out & otyper_q) == '0)
        else report_error("pad_out high on an open-drain pin");

    a_pause_enter: assert property (@(posedge clk) disable iff (rst)
        (pause_s2 && !pause_ack && !pready) |=> pause_ack)
        else report_error("pause_ack did not rise");

    a_pause_tieoff: assert property (@(posedge clk) disable iff (rst)
        pause_ack |-> (pready && pslverr))
        else report_error("bus not tied off with an error while paused");

    a_pause_exit: assert property (@(posedge clk) disable iff (rst)
        (!pause_s2 && pause_ack) |=> !pause_ack)
        else report_error("pause_ack did not fall after release");

    initial begin
        int bad_idx;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Byte-merged writes and readback
        for (int round = 0; round < 4; round++) begin
            for (int idx = 1; idx <= 6; idx++) begin
                write_reg(idx, next_bits(32), strb_t'(next_bits(STRB_WIDTH)));
                read_reg(idx);
            end
        end

        write_reg(REG_IDR, next_bits(32), '1);  // Read only
        for (int n = 0; n < 4; n++) begin
            bad_idx = 7 + int'(next_bits(9));
            write_reg(bad_idx, next_bits(32), '1);
            read_reg(bad_idx);
        end
        for (int idx = 0; idx <= 6; idx++) begin
            read_reg(idx);
        end

        // Input path and interrupt
        write_reg(REG_MODER, '0, '1);
        for (int n = 0; n < 8; n++) begin
            write_reg(REG_IER, next_bits(32), strb_t'(next_bits(STRB_WIDTH)));
            @(posedge clk);
            pin_pattern <= next_bits(32);
            repeat (2) @(posedge clk);
            read_reg(REG_IDR);
        end

        // Plain GPIO drive, push-pull and open-drain mixed
        write_reg(REG_FSR0, '0, '1);
        write_reg(REG_FSR1, '0, '1);
        for (int n = 0; n < 8; n++) begin
            write_reg(REG_OTYPER, next_bits(32), '1);
            write_reg(REG_MODER, next_bits(32), '1);
            write_reg(REG_ODR, next_bits(32), '1);
            repeat (2) @(posedge clk);
        end

        // Alternate functions
        write_reg(REG_MODER, '1, '1);
        for (int n = 0; n < 4; n++) begin
            write_reg(REG_FSR0, next_bits(32), '1);
            write_reg(REG_FSR1, next_bits(32), '1);
            repeat (8) begin
                @(posedge clk);
                alt_out_1 <= next_bits(32);
                alt_out_2 <= next_bits(32);
                alt_out_3 <= next_bits(32);
            end
        end

        // Pause with a live interrupt source
        write_reg(REG_MODER, '0, '1);
        write_reg(REG_IER, '1, '1);
        @(posedge clk);
        pin_pattern <= next_bits(32) | 32'h1;
        repeat (4) @(posedge clk);
        pause_req <= 1'b1;
        do @(posedge clk); while (!pause_ack);
        paused_phase = 1'b1;
        for (int idx = 1; idx <= 6; idx++) begin
            write_reg(idx, next_bits(32), '1);
            read_reg(idx);
        end
        repeat (4) @(posedge clk);
        paused_phase = 1'b0;
        pause_req <= 1'b0;
        do @(posedge clk); while (pause_ack);
        for (int idx = 1; idx <= 6; idx++) begin
            read_reg(idx);  // Values from before the pause
        end
        repeat (4) @(posedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/gpio_bus_pkg.sv
source/gpio_pin_pkg.sv
source/gpio_sync_stage.sv
source/gpio_apb_regs.sv
source/gpio_pad_drive.sv
source/gpio_top.sv
testbench/gpio_tb.sv
